// ==== wr_splitter_defines.svh ====
// Page, bus, length and queue size macros for the write splitter
`ifndef WR_SPLITTER_DEFINES_SVH
`define WR_SPLITTER_DEFINES_SVH

// --------------------
// Memory page
`define WS_PAGE_BYTES   4096    // Bytes per page

// --------------------
// Data bus
`define WS_DATA_W       128     // Beat width in bits
`define WS_BEAT_BYTES   16      // Bytes carried by one beat

// --------------------
// Address channel
`define WS_ADDR_W       64
`define WS_LEN_W        14      // Byte length of a request

// Beat count of one segment, a full page is 256 beats
`define WS_SEG_BEATS_W  9

// Segment control items in flight
`define WS_QUEUE_DEPTH  32

`endif

// ==== wr_splitter_pkg.sv ====
// Request, beat and segment control structs, FSM state enums
`include "wr_splitter_defines.svh"

package wr_splitter_pkg;

    // --------------------
    // Channel payloads

    // Address channel request or segment
    typedef struct packed {
        logic [`WS_ADDR_W-1:0] addr;   // Byte address
        logic [`WS_LEN_W-1:0]  len;    // Byte length
    } wr_req_t;

    // One data beat
    typedef struct packed {
        logic [`WS_DATA_W-1:0] data;
        logic                  last;   // End of burst
    } wr_beat_t;

    // --------------------
    // Address side to data side
    typedef struct packed {
        logic [`WS_SEG_BEATS_W-1:0] beats;      // Segment length in beats
        logic                       final_seg;  // Last segment of its request
    } seg_item_t;

    // --------------------
    // FSM states
    typedef enum logic [0:0] {
        SEG_IDLE,
        SEG_SPLIT
    } seg_state_t;

    typedef enum logic [0:0] {
        FRAME_IDLE,
        FRAME_RUN
    } frame_state_t;

endpackage

// ==== page_split_fsm.sv ====
// Address channel FSM cutting write requests into page-bounded segments
`timescale 1ns/1ns
`include "wr_splitter_defines.svh"

module page_split_fsm (
    input  logic                       clk,
    input  logic                       reset,
    input  wr_splitter_pkg::wr_req_t   req,
    input  logic                       req_valid,
    output logic                       req_ready,
    output wr_splitter_pkg::wr_req_t   seg,
    output logic                       seg_valid,
    input  logic                       seg_ready,
    output logic                       push,
    output wr_splitter_pkg::seg_item_t push_item,
    input  logic                       full
);
    import wr_splitter_pkg::*;

    localparam int ADDR_W      = `WS_ADDR_W;
    localparam int LEN_W       = `WS_LEN_W;
    localparam int SEG_BEATS_W = `WS_SEG_BEATS_W;
    localparam int OFFS_W      = $clog2(`WS_PAGE_BYTES);   // In-page offset bits
    localparam int BEAT_SHIFT  = $clog2(`WS_BEAT_BYTES);

    localparam logic [LEN_W-1:0] PAGE_LEN = LEN_W'(`WS_PAGE_BYTES);

    seg_state_t        state;
    seg_state_t        state_next;

    logic [ADDR_W-1:0] next_addr;   // Start of the following segment
    logic [LEN_W-1:0]  rem_len;     // Bytes of the request not yet emitted
    logic [LEN_W-1:0]  page_left;   // Bytes up to the end of the request's page
    logic [ADDR_W-1:0] cur_addr;
    logic [LEN_W-1:0]  cur_len;
    logic              last_seg;

    // --------------------
    // Current segment
    always_comb begin
        page_left = PAGE_LEN - LEN_W'(req.addr[OFFS_W-1:0]);

        case (state)
            SEG_IDLE: begin
                // First segment goes out with the request itself
                cur_addr  = req.addr;
                cur_len   = (req.len < page_left) ? req.len : page_left;
                last_seg  = (req.len <= page_left);
                seg_valid = req_valid && !full;
            end
            SEG_SPLIT: begin
                cur_addr  = next_addr;   // Page aligned from here on
                cur_len   = (rem_len < PAGE_LEN) ? rem_len : PAGE_LEN;
                last_seg  = (rem_len <= PAGE_LEN);
                seg_valid = !full;
            end
            default: begin
                cur_addr  = req.addr;
                cur_len   = req.len;
                last_seg  = 1'b1;
                seg_valid = 1'b0;
            end
        endcase

        seg.addr  = cur_addr;
        seg.len   = cur_len;
        push      = seg_valid && seg_ready;   // One control item per segment
        req_ready = (state == SEG_IDLE) && seg_ready && !full;

        push_item.beats     = cur_len[BEAT_SHIFT +: SEG_BEATS_W];
        push_item.final_seg = last_seg;
    end

    // --------------------
    // State transitions
    always_comb begin
        state_next = state;
        if (push) begin
            state_next = last_seg ? SEG_IDLE : SEG_SPLIT;
        end
    end

    always_ff @(posedge clk) begin
        if (reset) begin
            state <= SEG_IDLE;
        end else begin
            state <= state_next;
        end
    end

    // Advance past the emitted segment
    always_ff @(posedge clk) begin
        if (push) begin
            next_addr <= cur_addr + ADDR_W'(cur_len);
            rem_len   <= ((state == SEG_IDLE) ? req.len : rem_len) - cur_len;
        end
    end

    // --------------------
    // Checks

    // Beat-granular requests only
    a_req_aligned: assert property (
        @(posedge clk) disable iff (reset)
        req_valid |-> (req.addr[BEAT_SHIFT-1:0] == '0) && (req.len[BEAT_SHIFT-1:0] == '0)
    ) else $error("%t: request not aligned to %0d bytes", $time, `WS_BEAT_BYTES);

    a_req_nonzero: assert property (
        @(posedge clk) disable iff (reset)
        req_valid |-> (req.len != '0)
    ) else $error("%t: zero-length request", $time);

endmodule

// ==== ctrl_queue.sv ====
// Synchronous FIFO of segment control items
`timescale 1ns/1ns
`include "wr_splitter_defines.svh"

module ctrl_queue (
    input  logic                       clk,
    input  logic                       reset,
    input  logic                       push,
    input  wr_splitter_pkg::seg_item_t push_item,
    input  logic                       pop,
    output wr_splitter_pkg::seg_item_t head,
    output logic                       full,
    output logic                       empty
);
    import wr_splitter_pkg::*;

    localparam int DEPTH = `WS_QUEUE_DEPTH;
    localparam int PTR_W = $clog2(DEPTH);

    localparam logic [PTR_W:0] FULL_COUNT = DEPTH[PTR_W:0];

    seg_item_t        mem [DEPTH];

    logic [PTR_W-1:0] wr_ptr;
    logic [PTR_W-1:0] rd_ptr;
    logic [PTR_W:0]   count;   // Occupancy from 0 to DEPTH
    logic             do_push;
    logic             do_pop;

    assign do_push = push && !full;
    assign do_pop  = pop && !empty;

    assign full  = (count == FULL_COUNT);
    assign empty = (count == '0);
    assign head  = mem[rd_ptr];   // Oldest item

    // --------------------
    // Storage
    always_ff @(posedge clk) begin
        if (do_push) begin
            mem[wr_ptr] <= push_item;
        end
    end

    // --------------------
    // Pointers and count
    always_ff @(posedge clk) begin
        if (reset) begin
            wr_ptr <= '0;
            rd_ptr <= '0;
            count  <= '0;
        end else begin
            if (do_push) begin
                wr_ptr <= wr_ptr + 1'b1;   // Wraps at DEPTH
            end
            if (do_pop) begin
                rd_ptr <= rd_ptr + 1'b1;
            end
            case ({do_push, do_pop})
                2'b10:   count <= count + 1'b1;
                2'b01:   count <= count - 1'b1;
                default: count <= count;
            endcase
        end
    end

    // Address side holds off while the queue is full
    a_push_room: assert property (
        @(posedge clk) disable iff (reset)
        push |-> !full
    ) else $error("%t: push into full control queue", $time);

    // Data side may only close a segment that the address side issued
    a_pop_nonempty: assert property (
        @(posedge clk) disable iff (reset)
        pop |-> !empty
    ) else $error("%t: pop from empty control queue", $time);

endmodule

// ==== beat_framer.sv ====
// Data channel beat counter forwarding beats and marking segment ends
`timescale 1ns/1ns
`include "wr_splitter_defines.svh"

module beat_framer (
    input  logic                       clk,
    input  logic                       reset,
    input  wr_splitter_pkg::seg_item_t head,
    input  logic                       empty,
    output logic                       pop,
    input  wr_splitter_pkg::wr_beat_t  din,
    input  logic                       din_valid,
    output logic                       din_ready,
    output wr_splitter_pkg::wr_beat_t  dout,
    output logic                       dout_valid,
    input  logic                       dout_ready
);
    import wr_splitter_pkg::*;

    localparam int SEG_BEATS_W = `WS_SEG_BEATS_W;

    localparam logic [SEG_BEATS_W-1:0] ONE_BEAT = SEG_BEATS_W'(1);

    frame_state_t           state;
    frame_state_t           state_next;

    logic [SEG_BEATS_W-1:0] beat_cnt;   // Beats left in the running segment
    logic                   seg_end;    // Current beat closes the segment
    logic                   fire;

    // --------------------
    // Beat path
    always_comb begin
        // Count comes from the queue head until the first beat is taken
        if (state == FRAME_IDLE) begin
            seg_end = (head.beats == ONE_BEAT);
        end else begin
            seg_end = (beat_cnt == ONE_BEAT);
        end

        dout.data  = din.data;   // Unchanged
        dout.last  = seg_end;
        dout_valid = din_valid && !empty;
        din_ready  = dout_ready && !empty;

        fire = dout_valid && dout_ready;
        pop  = fire && seg_end;   // Segment done, drop its item
    end

    // --------------------
    // State and counter
    always_comb begin
        state_next = state;
        if (fire) begin
            state_next = seg_end ? FRAME_IDLE : FRAME_RUN;
        end
    end

    always_ff @(posedge clk) begin
        if (reset) begin
            state    <= FRAME_IDLE;
            beat_cnt <= '0;
        end else begin
            state <= state_next;
            if (fire) begin
                // Load on the first beat, count down afterwards
                beat_cnt <= ((state == FRAME_IDLE) ? head.beats : beat_cnt) - 1'b1;
            end
        end
    end

    // --------------------
    // Checks

    // Source burst ends only where the final segment of its request ends
    a_din_last: assert property (
        @(posedge clk) disable iff (reset)
        fire |-> (din.last == (seg_end && head.final_seg))
    ) else $error("%t: din.last off the final segment boundary", $time);

endmodule

// ==== wr_splitter.sv ====
// Top level of the 4 KiB page write splitter
`timescale 1ns/1ns

module wr_splitter (
    input  logic                      clk,
    input  logic                      reset,

    // Requests in
    input  wr_splitter_pkg::wr_req_t  req,
    input  logic                      req_valid,
    output logic                      req_ready,

    // Page-bounded segments out
    output wr_splitter_pkg::wr_req_t  seg,
    output logic                      seg_valid,
    input  logic                      seg_ready,

    // Data in
    input  wr_splitter_pkg::wr_beat_t din,
    input  logic                      din_valid,
    output logic                      din_ready,

    // Data out, one burst per segment
    output wr_splitter_pkg::wr_beat_t dout,
    output logic                      dout_valid,
    input  logic                      dout_ready
);
    import wr_splitter_pkg::*;

    // --------------------
    // Control queue wires
    seg_item_t push_item;
    seg_item_t head;
    logic      push;
    logic      pop;
    logic      full;
    logic      empty;

    page_split_fsm u_split (
        .clk       (clk),
        .reset     (reset),
        .req       (req),
        .req_valid (req_valid),
        .req_ready (req_ready),
        .seg       (seg),
        .seg_valid (seg_valid),
        .seg_ready (seg_ready),
        .push      (push),
        .push_item (push_item),
        .full      (full)
    );

    ctrl_queue u_queue (
        .clk       (clk),
        .reset     (reset),
        .push      (push),
        .push_item (push_item),
        .pop       (pop),
        .head      (head),
        .full      (full),
        .empty     (empty)
    );

    beat_framer u_framer (
        .clk        (clk),
        .reset      (reset),
        .head       (head),
        .empty      (empty),
        .pop        (pop),
        .din        (din),
        .din_valid  (din_valid),
        .din_ready  (din_ready),
        .dout       (dout),
        .dout_valid (dout_valid),
        .dout_ready (dout_ready)
    );

endmodule

// ==== tb_wr_splitter.sv ====
// Testbench for the page write splitter with reference model and checking assertions
`timescale 1ns/1ns
`include "wr_splitter_defines.svh"

module tb_wr_splitter;
    import wr_splitter_pkg::*;

    localparam logic [31:0] SEED    = 32'he8f9dbe3;
    localparam int          TIMEOUT = 5000;   // Cycles allowed per wait
    localparam int          PAGE    = `WS_PAGE_BYTES;
    localparam int          BEAT    = `WS_BEAT_BYTES;
    localparam int          OFFS_W  = $clog2(PAGE);

    localparam int MODE_INPAGE = 0;
    localparam int MODE_CROSS  = 1;
    localparam int MODE_SHORT  = 2;   // A few beats over a page end

    logic     clk = 1'b0;
    logic     reset;
    wr_req_t  req;
    logic     req_valid;
    logic     req_ready;
    wr_req_t  seg;
    logic     seg_valid;
    logic     seg_ready = 1'b0;
    wr_beat_t din;
    logic     din_valid;
    logic     din_ready;
    wr_beat_t dout;
    logic     dout_valid;
    logic     dout_ready = 1'b0;

    // --------------------
    // Reference model
    wr_req_t           exp_seg [4096];
    logic [BEAT*8-1:0] exp_data [65536];
    logic              exp_last [65536];
    logic [11:0]       seg_wr = '0;
    logic [11:0]       seg_rd;
    logic [15:0]       last_wr = '0;    // Beats framed by the model
    logic [15:0]       data_wr = '0;    // Beats handed to the DUT
    logic [15:0]       out_rd;
    int                accepted_len [$];

    logic [31:0] rng = SEED;
    logic        started = 1'b0;
    logic        timeout_hit = 1'b0;
    int          seg_pct = 0;
    int          dout_pct = 0;
    int          err_count = 0;
    int          test_count = 0;
    int          sent_beats = 0;
    int          seg_total;
    int          beat_total;
    int          full_cycles;

    wr_splitter uut (
        .clk        (clk),
        .reset      (reset),
        .req        (req),
        .req_valid  (req_valid),
        .req_ready  (req_ready),
        .seg        (seg),
        .seg_valid  (seg_valid),
        .seg_ready  (seg_ready),
        .din        (din),
        .din_valid  (din_valid),
        .din_ready  (din_ready),
        .dout       (dout),
        .dout_valid (dout_valid),
        .dout_ready (dout_ready)
    );

    always #20 clk = ~clk;

    function logic [31:0] next_random();
        rng = rng * 32'd1664525 + 32'd1013904223;
        return rng ^ (rng >> 16);   // Fold high bits into the weak low ones
    endfunction

    function int random_below(input int n);
        return int'(next_random() % 32'(n));
    endfunction

    function automatic logic [BEAT*8-1:0] beat_pattern(input int n);
        return {n, ~n, n * 3, n ^ 32'h9e3779b9};
    endfunction

    function automatic wr_req_t make_request(input int mode);
        wr_req_t r;
        int      offs;
        int      len;
        case (mode)
            MODE_INPAGE: begin
                offs = BEAT * random_below(PAGE / BEAT);
                len  = BEAT * (1 + random_below((PAGE - offs) / BEAT));
            end
            MODE_CROSS: begin
                offs = PAGE - BEAT * (1 + random_below(32));
                len  = BEAT * (1 + random_below(1023));   // 16 to 16368 bytes
            end
            default: begin
                offs = PAGE - BEAT;
                len  = BEAT * (2 + random_below(3));
            end
        endcase
        r.addr = (`WS_ADDR_W'(next_random()) << OFFS_W) + `WS_ADDR_W'(offs);
        r.len  = `WS_LEN_W'(len);
        return r;
    endfunction

    // Each piece runs up to the page end or the end of the request
    task automatic record_request(input wr_req_t r);
        wr_req_t cur;
        wr_req_t piece;
        int      rem;
        int      chunk;
        cur = r;
        rem = int'(r.len);
        while (rem > 0) begin
            chunk = PAGE - int'(cur.addr[OFFS_W-1:0]);
            if (chunk > rem) begin
                chunk = rem;
            end
            piece.addr = cur.addr;
            piece.len  = `WS_LEN_W'(chunk);
            exp_seg[seg_wr] = piece;
            seg_wr = seg_wr + 1'b1;
            for (int k = 1; k <= chunk / BEAT; k++) begin
                exp_last[last_wr] = (k == chunk / BEAT);   // Burst end
                last_wr = last_wr + 1'b1;
            end
            cur.addr = cur.addr + `WS_ADDR_W'(chunk);
            rem      = rem - chunk;
        end
    endtask

    // --------------------
    // Stimulus
    always @(posedge clk) begin
        seg_ready  <= started && ((next_random() % 32'd100) < 32'(seg_pct));
        dout_ready <= started && ((next_random() % 32'd100) < 32'(dout_pct));
    end

    task automatic drive_requests(input int n, input int mode);
        wr_req_t r;
        int      waited;
        logic    taken;
        @(posedge clk);
        for (int i = 0; i < n; i++) begin
            if (random_below(4) == 0) begin
                req_valid <= 1'b0;
                repeat (1 + random_below(3)) @(posedge clk);
            end
            r = make_request(mode);
            req       <= r;
            req_valid <= 1'b1;
            started   <= 1'b1;
            record_request(r);
            waited = 0;
            do begin
                @(posedge clk);
                waited++;
                taken = req_ready;
            end while (!taken && waited < TIMEOUT);
            if (!taken) begin
                $display("Timeout: request at %h was not accepted", r.addr);
                timeout_hit = 1'b1;
                break;
            end
            accepted_len.push_back(int'(r.len));
        end
        req_valid <= 1'b0;
    endtask

    task automatic send_data(input int n);
        int   beats;
        int   waited;
        logic taken;
        for (int i = 0; i < n && !timeout_hit; i++) begin
            waited = 0;
            do begin
                @(posedge clk);
                waited++;
            end while (accepted_len.size() == 0 && waited < TIMEOUT);
            if (accepted_len.size() == 0) begin
                $display("Timeout: no accepted request to send data for");
                timeout_hit = 1'b1;
                break;
            end
            beats = accepted_len.pop_front() / BEAT;
            for (int b = 0; b < beats; b++) begin
                if (random_below(4) == 0) begin
                    din_valid <= 1'b0;   // Gap
                    @(posedge clk);
                end
                din.data  <= beat_pattern(sent_beats);
                din.last  <= (b == beats - 1);
                din_valid <= 1'b1;
                exp_data[data_wr] = beat_pattern(sent_beats);
                data_wr    = data_wr + 1'b1;
                sent_beats = sent_beats + 1;
                waited = 0;
                do begin
                    @(posedge clk);
                    waited++;
                    taken = din_ready;
                end while (!taken && waited < TIMEOUT);
                if (!taken) begin
                    $display("Timeout: data beat %0d was not accepted", sent_beats - 1);
                    timeout_hit = 1'b1;
                    break;
                end
            end
            din_valid <= 1'b0;
        end
    endtask

    task automatic wait_drain();
        int   waited;
        logic done;
        waited = 0;
        do begin
            @(posedge clk);
            waited++;
            done = (seg_rd == seg_wr) && (out_rd == data_wr) && (out_rd == last_wr);
        end while (!done && waited < TIMEOUT);
        if (!done) begin
            $display("Timeout: segments or beats still outstanding at the end of a test");
            timeout_hit = 1'b1;
        end
    endtask

    task automatic run_test(input string name, input int n, input int mode,
                            input int sp, input int dp);
        int errs;
        int segs;
        int beats;
        errs     = err_count;
        segs     = seg_total;
        beats    = beat_total;
        seg_pct  = sp;
        dout_pct = dp;
        fork
            drive_requests(n, mode);
            send_data(n);
        join
        if (!timeout_hit) begin
            wait_drain();
        end
        test_count++;
        $display("Test %0d %s: %0d segments, %0d beats, %0d errors", test_count, name,
                 seg_total - segs, beat_total - beats, err_count - errs);
    endtask

    // --------------------
    // Checks
    always @(posedge clk) begin
        if (reset) begin
            seg_rd      <= '0;
            out_rd      <= '0;
            seg_total   <= 0;
            beat_total  <= 0;
            full_cycles <= 0;
        end else begin
            if (seg_valid && seg_ready) begin
                seg_rd    <= seg_rd + 1'b1;
                seg_total <= seg_total + 1;
            end
            if (dout_valid && dout_ready) begin
                out_rd     <= out_rd + 1'b1;
                beat_total <= beat_total + 1;
            end
            if (uut.full) full_cycles <= full_cycles + 1;
        end
    end

    a_idle_outputs: assert property (@(posedge clk) disable iff (reset)
        !started |-> !seg_valid && !dout_valid && !req_ready)
    else begin
        err_count++;
        $display("MISMATCH at time %0t: channel active before the first request", $time);
    end

    a_seg_in_page: assert property (@(posedge clk) disable iff (reset)
        seg_valid |-> (32'(seg.addr[OFFS_W-1:0]) + 32'(seg.len)) <= 32'(PAGE))
    else begin
        err_count++;
        $display("MISMATCH at time %0t: segment %h len %0d crosses a page", $time,
                 seg.addr, seg.len);
    end

    a_seg_match: assert property (@(posedge clk) disable iff (reset)
        seg_valid && seg_ready |-> (seg_rd != seg_wr) && (seg == exp_seg[seg_rd]))
    else begin
        err_count++;
        $display("MISMATCH at time %0t: segment %h len %0d, expected %h len %0d", $time,
                 seg.addr, seg.len, exp_seg[seg_rd].addr, exp_seg[seg_rd].len);
    end

    a_beat_data: assert property (@(posedge clk) disable iff (reset)
        dout_valid && dout_ready |-> (out_rd != data_wr) && (dout.data == exp_data[out_rd]))
    else begin
        err_count++;
        $display("MISMATCH at time %0t: beat %0d data %h, expected %h", $time, out_rd,
                 dout.data, exp_data[out_rd]);
    end

    a_beat_last: assert property (@(posedge clk) disable iff (reset)
        dout_valid && dout_ready |-> dout.last == exp_last[out_rd])
    else begin
        err_count++;
        $display("MISMATCH at time %0t: beat %0d last %b, expected %b", $time, out_rd,
                 dout.last, exp_last[out_rd]);
    end

    initial begin
        reset     = 1'b1;
        req       = '0;
        req_valid = 1'b0;
        din       = '0;
        din_valid = 1'b0;
        repeat (3) @(posedge clk);
        reset <= 1'b0;
        repeat (8) @(posedge clk);   // Quiet window after reset
        test_count++;
        $display("Test %0d idle after reset: %0d errors", test_count, err_count);
        run_test("requests within a page", 20, MODE_INPAGE, 100, 100);
        if (!timeout_hit) run_test("page crossing with back-pressure", 30, MODE_CROSS, 70, 60);
        if (!timeout_hit) run_test("control queue full", 40, MODE_SHORT, 100, 5);
        if (!timeout_hit) run_test("long requests with gaps", 15, MODE_CROSS, 40, 90);
        $display("Summary: %0d tests, %0d segments, %0d beats, %0d queue-full cycles, %0d errors",
                 test_count, seg_total, beat_total, full_cycles, err_count);
        if (err_count == 0 && !timeout_hit) begin
            $display("Test completed successfully");
        end else begin
            $display("Test failed");
        end
        $finish;
    end

endmodule

// ==== wr_splitter.f ====
+incdir+.
wr_splitter_pkg.sv
page_split_fsm.sv
ctrl_queue.sv
beat_framer.sv
wr_splitter.sv
tb_wr_splitter.sv

// ==== run.sh ====
#!/bin/sh
# Build and run the write splitter testbench with Verilator

cd "$(dirname "$0")" || exit 1

LOG=sim.log

verilator --binary --timing --assert --timescale 1ns/1ns -Wno-fatal -j 0 \
    --top-module tb_wr_splitter -f wr_splitter.f -o sim_wr_splitter
if [ $? -ne 0 ]; then
    echo "Verilator build failed"
    exit 1
fi

./obj_dir/sim_wr_splitter > "$LOG" 2>&1
status=$?
cat "$LOG"
if [ $status -ne 0 ]; then
    echo "Simulation exited with status $status"
    exit 1
fi

if grep -q "Test failed" "$LOG"; then
    echo "FAIL"
    exit 1
fi
echo "PASS"
exit 0
